/* Bender.yml */
package:
  name: cache

sources:
  - include_dirs:
      - include
    files:
      - hw/cache_pkg.sv
      - hw/byte_aligner.sv
      - hw/cache_tag_store.sv
      - hw/cache_data_array.sv
      - hw/cache_ctrl.sv
      - hw/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/bus_memory.sv
      - testbench/cache_tb.sv

/* all.f */
+incdir+include
hw/cache_pkg.sv
hw/byte_aligner.sv
hw/cache_tag_store.sv
hw/cache_data_array.sv
hw/cache_ctrl.sv
hw/cache_top.sv
testbench/bus_memory.sv
testbench/cache_tb.sv

/* hw/byte_aligner.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module byte_aligner
   import cache_pkg::*;
(
   // start byte inside the line
   input  wire [`CACHE_OFFSET_W-1:0] offset,
   // access length minus one
   input  wire [`CACHE_OFFSET_W-1:0] size,
   input  wire cache_line_t          data_write,
   input  wire cache_line_t          line_rdata,
   output cache_line_t               store_data,
   output byte_mask_t                byte_mask,
   output cache_line_t               data_read
);

   // byte offset turned into a bit shift
   logic [`CACHE_OFFSET_W+2:0] bit_shift;

   // line moved down so the addressed byte sits at byte 0
   cache_line_t line_shifted;

   assign bit_shift = {offset, 3'b000};

   // processor byte 0 lands on line byte offset
   // anything pushed past the top falls off
   assign store_data = data_write << bit_shift;

   // high bytes fill with zero, covers the past-end case
   assign line_shifted = line_rdata >> bit_shift;

   // mask bit j covers line byte j
   // set when offset <= j and j - offset <= size
   always_comb begin
      byte_mask = '0;
      for (int j = 0; j < `CACHE_LINE_BYTES; j++) begin
         if ((j >= offset) && ((j - offset) <= size)) begin
            byte_mask[j] = 1'b1;
         end
      end
   end

   // keep only the requested bytes
   always_comb begin
      data_read = '0;
      for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
         if (i <= size) begin
            data_read[i*8 +: 8] = line_shifted[i*8 +: 8];
         end
      end
   end

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl
   import cache_pkg::*;
(
   input  wire                      clk,
   input  wire                      reset,
   // processor request
   input  wire                      enable,
   input  wire                      rw,
   input  wire [`CACHE_ADDR_W-1:0]  address,
   // lookup result from the tag store
   input  wire                      hit,
   input  wire                      victim_dirty,
   input  wire [`CACHE_TAG_W-1:0]   victim_tag,
   // memory answer
   input  wire                      bus_r,
   output logic                     ready,
   output logic                     store_wr,
   output logic                     fill_wr,
   output logic                     bus_en,
   output logic                     bus_wr,
   output logic [`CACHE_ADDR_W-1:0] bus_addr
);

   cache_state_t state;
   cache_state_t next_state;

   logic [`CACHE_TAG_W-1:0]   req_tag;
   logic [`CACHE_INDEX_W-1:0] req_index;

   // address fields of the pending request
   assign req_tag   = address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign req_index = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         idle: begin
            // request held until ready, so one sample is enough
            if (enable) begin
               next_state = compare;
            end
         end
         compare: begin
            if (hit) begin
               next_state = done;
            end else if (victim_dirty) begin
               next_state = write_back;
            end else begin
               // clean or empty victim, just overwrite it
               next_state = fill;
            end
         end
         write_back: begin
            // wait on memory, no other back-pressure
            if (bus_r) begin
               next_state = fill;
            end
         end
         fill: begin
            // line lands on this edge, look it up again
            if (bus_r) begin
               next_state = compare;
            end
         end
         done: begin
            next_state = idle;
         end
         default: begin
            next_state = idle;
         end
      endcase
   end

   // processor handshake, one cycle in done
   assign ready = (state == done);

   // store bytes only once the line is resident
   assign store_wr = (state == compare) && hit && rw;

   // fill data is only valid while bus_r is up
   assign fill_wr = (state == fill) && bus_r;

   // bus request held for the whole wait
   assign bus_en = (state == write_back) || (state == fill);
   assign bus_wr = (state == write_back);

   // victim line goes out under its old tag
   // fill fetches the requested line, both line aligned
   always_comb begin
      if (state == write_back) begin
         bus_addr = {victim_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
      end else begin
         bus_addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
      end
   end

endmodule

`default_nettype wire

/* hw/cache_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_data_array
   import cache_pkg::*;
(
   input  wire                      clk,
   input  wire [`CACHE_INDEX_W-1:0] index,
   // whole line from the bus
   input  wire                      fill_wr,
   input  wire cache_line_t         fill_data,
   // partial line from the processor
   input  wire                      store_wr,
   input  wire byte_mask_t          byte_mask,
   input  wire cache_line_t         store_data,
   output cache_line_t              line_rdata
);

   // line storage, no reset on contents
   cache_line_t line_mem [`CACHE_LINES];

   always_ff @(posedge clk) begin
      if (fill_wr) begin
         // refill replaces every byte
         line_mem[index] <= fill_data;
      end else if (store_wr) begin
         // byte lanes picked by the aligner mask
         for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
            if (byte_mask[i]) begin
               line_mem[index][i*8 +: 8] <= store_data[i*8 +: 8];
            end
         end
      end
   end

   // async read, feeds both the aligner and the bus
   assign line_rdata = line_mem[index];

endmodule

`default_nettype wire

/* hw/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

   // one full line, byte 0 in the low bits
   typedef logic [`CACHE_LINE_BYTES*8-1:0] cache_line_t;

   // one enable per line byte
   typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;

   // controller states
   // a miss loops fill -> compare so the retry always hits
   typedef enum logic [2:0] {
      idle,
      compare,
      write_back,
      fill,
      done
   } cache_state_t;

endpackage

`default_nettype wire

/* hw/cache_tag_store.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tag_store (
   input  wire                      clk,
   input  wire                      reset,
   input  wire [`CACHE_INDEX_W-1:0] index,
   input  wire [`CACHE_TAG_W-1:0]   tag,
   // write hit marks the line modified
   input  wire                      store_wr,
   // refill installs a new clean line
   input  wire                      fill_wr,
   output logic                     hit,
   output logic                     victim_dirty,
   output logic [`CACHE_TAG_W-1:0]  victim_tag
);

   // tag bits, contents meaningless until valid
   logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];

   // status bits, cleared on reset
   logic [`CACHE_LINES-1:0] valid_q;
   logic [`CACHE_LINES-1:0] dirty_q;

   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_mem[index] <= tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_wr) begin
         // freshly fetched line matches memory
         valid_q[index] <= 1'b1;
         dirty_q[index] <= 1'b0;
      end else if (store_wr) begin
         dirty_q[index] <= 1'b1;
      end
   end

   // combinational lookup of the indexed entry
   assign victim_tag = tag_mem[index];

   // tag compare only counts on a valid entry
   assign hit = valid_q[index] && (tag_mem[index] == tag);

   // only valid modified lines need a write-back
   assign victim_dirty = valid_q[index] && dirty_q[index];

endmodule

`default_nettype wire

/* hw/cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top
   import cache_pkg::*;
(
   input  wire                       clk,
   input  wire                       reset,
   // processor port
   input  wire                       enable,
   input  wire                       rw,
   input  wire [`CACHE_ADDR_W-1:0]   address,
   input  wire [`CACHE_OFFSET_W-1:0] size,
   input  wire cache_line_t          data_write,
   output cache_line_t               data_read,
   output logic                      ready,
   // line-wide memory bus
   output logic                      bus_wr,
   output logic                      bus_en,
   output logic [`CACHE_ADDR_W-1:0]  bus_addr,
   output cache_line_t               bus_write,
   input  wire                       bus_r,
   input  wire cache_line_t          bus_read
);

   logic [`CACHE_TAG_W-1:0]    tag;
   logic [`CACHE_INDEX_W-1:0]  index;
   logic [`CACHE_OFFSET_W-1:0] offset;

   logic                    hit;
   logic                    victim_dirty;
   logic [`CACHE_TAG_W-1:0] victim_tag;
   logic                    store_wr;
   logic                    fill_wr;

   cache_line_t store_data;
   byte_mask_t  byte_mask;
   cache_line_t line_rdata;

   // tag | index | offset
   assign tag    = address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign index  = address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
   assign offset = address[`CACHE_OFFSET_W-1:0];

   cache_ctrl ctrl_i (
      .clk          (clk),
      .reset        (reset),
      .enable       (enable),
      .rw           (rw),
      .address      (address),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag),
      .bus_r        (bus_r),
      .ready        (ready),
      .store_wr     (store_wr),
      .fill_wr      (fill_wr),
      .bus_en       (bus_en),
      .bus_wr       (bus_wr),
      .bus_addr     (bus_addr)
   );

   cache_tag_store tag_store_i (
      .clk          (clk),
      .reset        (reset),
      .index        (index),
      .tag          (tag),
      .store_wr     (store_wr),
      .fill_wr      (fill_wr),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag)
   );

   cache_data_array data_array_i (
      .clk        (clk),
      .index      (index),
      .fill_wr    (fill_wr),
      .fill_data  (bus_read),
      .store_wr   (store_wr),
      .byte_mask  (byte_mask),
      .store_data (store_data),
      .line_rdata (line_rdata)
   );

   byte_aligner aligner_i (
      .offset     (offset),
      .size       (size),
      .data_write (data_write),
      .line_rdata (line_rdata),
      .store_data (store_data),
      .byte_mask  (byte_mask),
      .data_read  (data_read)
   );

   // victim data leaves straight from the array read port
   assign bus_write = line_rdata;

endmodule

`default_nettype wire

/* include/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address seen by the processor and the bus
`define CACHE_ADDR_W 16

// line geometry
`define CACHE_LINE_BYTES 16
`define CACHE_OFFSET_W 4

// direct mapped, one line per index
`define CACHE_INDEX_W 5
`define CACHE_LINES 32

// whatever is left above index and offset
`define CACHE_TAG_W 7

`endif

/* testbench/bus_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module bus_memory
   import cache_pkg::*;
(
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      bus_en,
   input  wire                      bus_wr,
   input  wire [`CACHE_ADDR_W-1:0]  bus_addr,
   input  wire cache_line_t         bus_write,
   output logic                     bus_r,
   output cache_line_t              bus_read
);

   localparam int MEM_LINES = 4096;
   localparam int MIN_DELAY = 1;
   localparam int MAX_DELAY = 4;

   // whole 64 KiB space, one entry per line
   cache_line_t mem [MEM_LINES];

   logic [31:0] rng_state;
   logic        busy;
   int          wait_left;
   logic [11:0] line_idx;

   // line number, offset bits ignored
   assign line_idx = bus_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // every address bit feeds the byte value
   function automatic logic [7:0] pattern_byte(input logic [15:0] a);
      return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3c;
   endfunction

   initial begin
      logic [15:0] a;
      rng_state = 32'h9062_4226;
      busy      = 1'b0;
      wait_left = 0;
      bus_r     = 1'b0;
      bus_read  = '0;
      for (int l = 0; l < MEM_LINES; l++) begin
         for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            a = 16'(l * `CACHE_LINE_BYTES + b);
            mem[l][b*8 +: 8] = pattern_byte(a);
         end
      end
   end

   always @(posedge clk) begin
      if (reset) begin
         bus_r <= 1'b0;
         busy  <= 1'b0;
      end else if (bus_r) begin
         // single cycle answer, cache leaves the wait state on this edge
         bus_r <= 1'b0;
         busy  <= 1'b0;
      end else if (busy) begin
         if (wait_left <= 1) begin
            bus_r <= 1'b1;
            if (bus_wr) begin
               mem[line_idx] <= bus_write;
            end else begin
               bus_read <= mem[line_idx];
            end
         end else begin
            wait_left <= wait_left - 1;
         end
      end else if (bus_en) begin
         // new request, draw a latency of 1 to 4 cycles
         rng_state = xorshift32(rng_state);
         busy      <= 1'b1;
         wait_left <= MIN_DELAY + int'(rng_state % (MAX_DELAY - MIN_DELAY + 1));
      end
   end

endmodule

`default_nettype wire

/* testbench/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb
   import cache_pkg::*;
();

   // about 300 accesses at up to 20 cycles, plus slack
   localparam int MAX_ACCESSES   = 300;
   localparam int WORST_CYCLES   = 20;
   localparam int TIMEOUT_CYCLES = MAX_ACCESSES * WORST_CYCLES + 2000;
   // drive edge, sampling edge, then ready two edges later
   localparam int HIT_EDGES      = 3;
   localparam int RANDOM_OPS     = 200;

   logic                       clk;
   logic                       reset;
   logic                       enable;
   logic                       rw;
   logic [`CACHE_ADDR_W-1:0]   address;
   logic [`CACHE_OFFSET_W-1:0] size;
   cache_line_t                data_write;
   cache_line_t                data_read;
   logic                       ready;
   logic                       bus_wr;
   logic                       bus_en;
   logic [`CACHE_ADDR_W-1:0]   bus_addr;
   cache_line_t                bus_write;
   logic                       bus_r;
   cache_line_t                bus_read;

   // byte-wide picture of memory as the processor sees it
   logic [7:0] model_mem [1 << `CACHE_ADDR_W];
   logic [31:0] rng_state;

   int errors       = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int cycle_count  = 0;

   // bus monitor state
   int                     bus_busy_cycles = 0;
   int                     bus_events      = 0;
   int                     wb_count        = 0;
   int                     fill_count      = 0;
   int                     wb_seq          = 0;
   int                     fill_seq        = 0;
   logic [`CACHE_ADDR_W-1:0] last_wb_addr;
   logic [`CACHE_ADDR_W-1:0] last_fill_addr;
   cache_line_t            last_wb_data;

   cache_top dut_i (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .rw         (rw),
      .address    (address),
      .size       (size),
      .data_write (data_write),
      .data_read  (data_read),
      .ready      (ready),
      .bus_wr     (bus_wr),
      .bus_en     (bus_en),
      .bus_addr   (bus_addr),
      .bus_write  (bus_write),
      .bus_r      (bus_r),
      .bus_read   (bus_read)
   );

   bus_memory mem_i (
      .clk       (clk),
      .reset     (reset),
      .bus_en    (bus_en),
      .bus_wr    (bus_wr),
      .bus_addr  (bus_addr),
      .bus_write (bus_write),
      .bus_r     (bus_r),
      .bus_read  (bus_read)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   // completed bus transfers, counted on the bus_r edge
   always @(posedge clk) begin
      if (bus_en === 1'b1) begin
         bus_busy_cycles++;
      end
      if (bus_en === 1'b1 && bus_r === 1'b1) begin
         bus_events++;
         if (bus_wr) begin
            wb_count++;
            wb_seq       = bus_events;
            last_wb_addr = bus_addr;
            last_wb_data = bus_write;
         end else begin
            fill_count++;
            fill_seq       = bus_events;
            last_fill_addr = bus_addr;
         end
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic cache_line_t random_line();
      return {next_random(), next_random(), next_random(), next_random()};
   endfunction

   // same start contents as the bus memory
   function automatic logic [7:0] pattern_byte(input logic [15:0] a);
      return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3c;
   endfunction

   // bytes past the requested size or the line end read as zero
   function automatic cache_line_t expected_read(input logic [15:0] addr,
                                                 input logic [3:0] sz);
      cache_line_t r;
      int          off;
      r   = '0;
      off = addr[3:0];
      for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
         if (i <= sz && off + i <= `CACHE_LINE_BYTES - 1) begin
            r[i*8 +: 8] = model_mem[addr + i];
         end
      end
      return r;
   endfunction

   function automatic cache_line_t model_line(input logic [15:0] addr);
      cache_line_t r;
      for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
         r[i*8 +: 8] = model_mem[{addr[15:4], 4'h0} + i];
      end
      return r;
   endfunction

   task automatic model_write(input logic [15:0] addr, input logic [3:0] sz,
                              input cache_line_t wdata);
      int off;
      off = addr[3:0];
      for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
         if (i <= sz && off + i <= `CACHE_LINE_BYTES - 1) begin
            model_mem[addr + i] = wdata[i*8 +: 8];
         end
      end
   endtask

   task automatic log_mismatch(input string msg);
      errors++;
      $display("ERROR @%0t: %s", $time, msg);
   endtask

   // one processor access, returns read data and edges until ready
   task automatic run_access(input logic wr, input logic [15:0] addr,
                             input logic [3:0] sz, input cache_line_t wdata,
                             output cache_line_t rdata, output int cycles);
      @(posedge clk);
      enable     <= 1'b1;
      rw         <= wr;
      address    <= addr;
      size       <= sz;
      data_write <= wdata;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (ready !== 1'b1);
      rdata = data_read;
      // enable low in the cycle after ready
      enable <= 1'b0;
   endtask

   task automatic check_read(input logic [15:0] addr, input logic [3:0] sz,
                             output int cycles);
      cache_line_t got;
      cache_line_t exp;
      exp = expected_read(addr, sz);
      run_access(1'b0, addr, sz, '0, got, cycles);
      if (got !== exp) begin
         log_mismatch($sformatf("read %h size %0d got %h expected %h", addr, sz, got, exp));
      end
   endtask

   task automatic write_bytes(input logic [15:0] addr, input logic [3:0] sz,
                              input cache_line_t wdata, output int cycles);
      cache_line_t unused;
      run_access(1'b1, addr, sz, wdata, unused, cycles);
      model_write(addr, sz, wdata);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors > errors_before) begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end else begin
         $display("%s: passed", name);
      end
   endtask

   task automatic reset_test();
      int e0;
      int cyc;
      int fills0;
      int wbs0;
      e0 = errors;
      if (ready !== 1'b0 || bus_en !== 1'b0) begin
         log_mismatch("ready or bus_en not low after reset");
      end
      fills0 = fill_count;
      wbs0   = wb_count;
      // cold cache, must go to the bus
      check_read(16'h1234, 4'd3, cyc);
      if (fill_count != fills0 + 1) begin
         log_mismatch($sformatf("first read made %0d fills", fill_count - fills0));
      end
      if (wb_count != wbs0) begin
         log_mismatch("first read wrote to the bus");
      end
      if (last_fill_addr !== 16'h1230) begin
         log_mismatch($sformatf("fill address %h expected 1230", last_fill_addr));
      end
      finish_test("reset and first miss", e0);
   endtask

   task automatic read_hit_test();
      int e0;
      int cyc;
      int busy0;
      e0    = errors;
      busy0 = bus_busy_cycles;
      check_read(16'h123a, 4'd1, cyc);
      if (cyc != HIT_EDGES) begin
         log_mismatch($sformatf("read hit took %0d edges", cyc));
      end
      if (bus_busy_cycles != busy0) begin
         log_mismatch("read hit used the bus");
      end
      finish_test("read hit", e0);
   endtask

   task automatic write_hit_test();
      logic [15:0] addrs [5];
      logic [3:0]  sizes [5];
      int e0;
      int cyc;
      int busy0;
      e0 = errors;
      // line 0x1230 is resident from the first test
      addrs = '{16'h1230, 16'h1235, 16'h123d, 16'h123f, 16'h1238};
      sizes = '{4'd0, 4'd3, 4'd5, 4'd15, 4'd7};
      // neighbour line resident, a spill past the line end would land in it
      check_read(16'h1240, 4'd15, cyc);
      for (int k = 0; k < 5; k++) begin
         busy0 = bus_busy_cycles;
         write_bytes(addrs[k], sizes[k], random_line(), cyc);
         if (cyc != HIT_EDGES || bus_busy_cycles != busy0) begin
            log_mismatch($sformatf("write to %h was not a plain hit", addrs[k]));
         end
      end
      check_read(16'h1230, 4'd15, cyc);
      // past-end bytes come back zero
      check_read(16'h123e, 4'd7, cyc);
      check_read(16'h123c, 4'd15, cyc);
      // neighbour line untouched by the overflowing writes
      check_read(16'h1240, 4'd15, cyc);
      finish_test("write hits", e0);
   endtask

   task automatic write_back_test();
      cache_line_t exp_wb;
      int e0;
      int cyc;
      int wb0;
      int fill0;
      e0 = errors;
      // same index 7, tags 0 and 1
      write_bytes(16'h0072, 4'd5, random_line(), cyc);
      exp_wb = model_line(16'h0070);
      wb0    = wb_count;
      fill0  = fill_count;
      check_read(16'h0271, 4'd9, cyc);
      if (wb_count != wb0 + 1) begin
         log_mismatch($sformatf("dirty eviction made %0d write-backs", wb_count - wb0));
      end
      if (last_wb_addr !== 16'h0070) begin
         log_mismatch($sformatf("write-back address %h expected 0070", last_wb_addr));
      end
      if (last_wb_data !== exp_wb) begin
         log_mismatch($sformatf("write-back data %h expected %h", last_wb_data, exp_wb));
      end
      if (fill_count != fill0 + 1 || last_fill_addr !== 16'h0270) begin
         log_mismatch("no fill of line 0270 after the write-back");
      end
      if (fill_seq < wb_seq) begin
         log_mismatch("fill came before the write-back");
      end
      // old line back from memory with the written bytes
      check_read(16'h0070, 4'd15, cyc);
      finish_test("dirty write-back", e0);
   endtask

   task automatic clean_evict_test();
      int e0;
      int cyc;
      int wb0;
      e0 = errors;
      // index 8, tags 2 and 3, never written
      check_read(16'h0480, 4'd15, cyc);
      wb0 = wb_count;
      check_read(16'h0684, 4'd3, cyc);
      check_read(16'h0488, 4'd7, cyc);
      if (wb_count != wb0) begin
         log_mismatch("clean eviction wrote to the bus");
      end
      finish_test("clean eviction", e0);
   endtask

   task automatic random_test();
      logic [31:0] r;
      logic [15:0] addr;
      int          e0;
      int          cyc;
      e0 = errors;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         r = next_random();
         // tags 0..3, indices 0..3, so evictions are frequent
         addr = {5'b0, r[1:0], 3'b0, r[3:2], r[7:4]};
         if (r[12]) begin
            write_bytes(addr, r[11:8], random_line(), cyc);
         end else begin
            check_read(addr, r[11:8], cyc);
         end
      end
      finish_test("random sequence", e0);
   endtask

   initial begin
      reset      = 1'b1;
      enable     = 1'b0;
      rw         = 1'b0;
      address    = '0;
      size       = '0;
      data_write = '0;
      rng_state  = 32'h9062_4226;
      for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
         model_mem[a] = pattern_byte(16'(a));
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      reset_test();
      read_hit_test();
      write_hit_test();
      write_back_test();
      clean_evict_test();
      random_test();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
